/* common/ctx_cfg.svh */
`ifndef CTX_CFG_SVH
`define CTX_CFG_SVH

// --------------------------------------------------
// Context sequencer status code
// --------------------------------------------------

// Width of the status code
// One code per sequencer state, 22 states fit in 5 bits
`define CTX_STATUS_W 5

// Reserved status codes

// Idle, waiting for a job start
`define CTX_STATUS_IDLE 0
// Job finished, shown for a single cycle before idle
`define CTX_STATUS_DONE 21
// State register holds a code outside the state set
`define CTX_STATUS_INVALID 31

`endif

/* common/ctx_pkg.sv */
`include "ctx_cfg.svh"

package ctx_pkg;

    // --------------------------------------------------
    // Status and state encodings
    // --------------------------------------------------

    // Sequencer state code as seen outside the controller
    typedef logic [`CTX_STATUS_W-1:0] ctx_status_t;

    // Main sequencer states
    // Each value doubles as the external status code
    typedef enum logic [`CTX_STATUS_W-1:0] {
        IDLE                = 0,
        // Single pass through the preload and first shift
        START_FLAGS         = 1,
        ARRAY_PREP          = 2,
        FIRST_SHIFT         = 3,
        START_COMP          = 4,
        WAIT_CSWITCH        = 5,
        WAIT_CSWITCH_STALL  = 6,
        WAIT_OBUF           = 7,
        WAIT_OBUF_STALL     = 8,
        SCND_SHIFT          = 9,
        SCND_SHIFT_STALL    = 10,
        ALL_BUSY_SHIFT      = 11,
        ALL_BUSY            = 12,
        ARRAY_BUSY          = 13,
        // Context loop, repeated once per programmed context
        OBUF_BUSY_SHIFT     = 14,
        FORCE_STALL         = 15,
        OBUF_BUSY           = 16,
        ARRAY_CSWITCH       = 17,
        ARRAY_CSWITCH_STALL = 18,
        // Last iteration only
        LAST_SHIFT          = 19,
        LAST_WAIT           = 20,
        DONE                = 21
    } ctx_state_e;

    // Array pipeline stall machine
    typedef enum logic {
        ARRAY_STALL  = 1'b0,
        ARRAY_ACTIVE = 1'b1
    } stall_state_e;

    // --------------------------------------------------
    // Grouped control signals
    // --------------------------------------------------

    // Levels from interface, output buffer, cswitch controller and feeders
    typedef struct packed {
        logic start;
        logic outbuf_done;
        logic cdone;
        logic cswitch_done;
        logic shift_done;
        logic finalwrite;
        logic feeders_done;
        logic pipeline_en;
    } ctx_event_t;

    // Level commands driven by the sequencer
    typedef struct packed {
        logic feeders_start;
        logic feeders_reset;
        logic pop_gate;
        logic outbuf_reset;
        logic cswitch_en;
        logic cswitch_force;
        logic done;
    } ctx_cmd_t;

    // Requests from the sequencer to the stall machine
    typedef struct packed {
        logic computation_ready;
        logic force_stall;
        logic stall_reset;
    } stall_req_t;

endpackage

/* sequencer/ctx_sequencer.sv */
`timescale 1ns/1ps
`include "ctx_cfg.svh"

module ctx_sequencer (
    input  logic                 i_clk,
    input  logic                 i_rstn,
    // Event levels from the neighbouring blocks
    input  ctx_pkg::ctx_event_t  i_evt,
    // Output buffer done, live or remembered since the last start
    input  logic                 i_done_hold,
    // Level commands to feeders, output buffer, cswitch and interface
    output ctx_pkg::ctx_cmd_t    o_cmd,
    // Requests to the pipeline stall machine
    output ctx_pkg::stall_req_t  o_stall_req,
    // Output buffer enable, its rising edge becomes the start pulse
    output logic                 o_outbuf_enable,
    output ctx_pkg::ctx_status_t o_status
);

    import ctx_pkg::*;

    ctx_state_e state_q;
    ctx_state_e state_d;

    // --------------------------------------------------
    // State register
    // --------------------------------------------------

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------------------------------------
    // Transition logic
    // --------------------------------------------------

    // Event levels and the held buffer done meet here
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:        if (i_evt.start) state_d = START_FLAGS;
            START_FLAGS: state_d = ARRAY_PREP;
            // Preload of context 0 read by the output buffer
            ARRAY_PREP:  if (i_done_hold) state_d = FIRST_SHIFT;
            FIRST_SHIFT: if (i_evt.shift_done) state_d = START_COMP;
            // Pipeline may run from here, first context switch forced
            START_COMP:  if (i_evt.pipeline_en) state_d = WAIT_CSWITCH;
            WAIT_CSWITCH: begin
                if (i_evt.cdone && i_evt.cswitch_done) begin
                    state_d = WAIT_OBUF_STALL;
                end else if (i_evt.cdone) begin
                    state_d = WAIT_CSWITCH_STALL;
                end else if (i_evt.cswitch_done) begin
                    state_d = WAIT_OBUF;
                end
            end
            // Context finished early, FIFO pop held off
            WAIT_CSWITCH_STALL: if (i_evt.cswitch_done) state_d = WAIT_OBUF_STALL;
            WAIT_OBUF: begin
                if (i_evt.cdone && i_done_hold) begin
                    state_d = SCND_SHIFT_STALL;
                end else if (i_evt.cdone) begin
                    state_d = WAIT_OBUF_STALL;
                end else if (i_done_hold) begin
                    state_d = SCND_SHIFT;
                end
            end
            WAIT_OBUF_STALL: if (i_done_hold) state_d = SCND_SHIFT_STALL;
            // One cycle, second buffer start
            SCND_SHIFT: state_d = i_evt.cdone ? OBUF_BUSY_SHIFT : ALL_BUSY_SHIFT;
            SCND_SHIFT_STALL: if (i_done_hold) state_d = ARRAY_CSWITCH;
            // Everything busy while the buffer shifts
            ALL_BUSY_SHIFT: begin
                if (i_evt.shift_done && i_evt.cdone) begin
                    state_d = FORCE_STALL;
                end else if (i_evt.cdone) begin
                    state_d = OBUF_BUSY_SHIFT;
                end else if (i_evt.shift_done) begin
                    state_d = ALL_BUSY;
                end
            end
            ALL_BUSY: begin
                if (i_done_hold && i_evt.cdone) begin
                    state_d = ARRAY_CSWITCH;
                end else if (i_done_hold) begin
                    state_d = ARRAY_BUSY;
                end else if (i_evt.cdone) begin
                    state_d = OBUF_BUSY;
                end
            end
            // Buffer idle until the array ends its context
            ARRAY_BUSY: if (i_evt.cdone) state_d = ARRAY_CSWITCH;
            // Loop head, array computes while the context switches
            ARRAY_CSWITCH: begin
                if (i_evt.cdone && i_evt.cswitch_done) begin
                    if (i_evt.feeders_done && i_evt.finalwrite) begin
                        state_d = LAST_SHIFT;
                    end else begin
                        state_d = OBUF_BUSY_SHIFT;
                    end
                end else if (i_evt.cdone) begin
                    state_d = ARRAY_CSWITCH_STALL;
                end else if (i_evt.cswitch_done) begin
                    if (i_evt.feeders_done && i_evt.finalwrite) begin
                        state_d = LAST_SHIFT;
                    end else begin
                        state_d = ALL_BUSY_SHIFT;
                    end
                end
            end
            // Only the final write flag selects the last section here
            // Feeders done is not looked at in this state
            ARRAY_CSWITCH_STALL: begin
                if (i_evt.cswitch_done) begin
                    state_d = i_evt.finalwrite ? LAST_SHIFT : OBUF_BUSY_SHIFT;
                end
            end
            // Array shifts zeros while the buffer fetches
            OBUF_BUSY_SHIFT: begin
                if (i_done_hold) begin
                    state_d = ARRAY_CSWITCH;
                end else if (i_evt.shift_done) begin
                    state_d = FORCE_STALL;
                end
            end
            // One cycle to push the stall machine into stall
            FORCE_STALL: state_d = i_done_hold ? ARRAY_CSWITCH : OBUF_BUSY;
            OBUF_BUSY:   if (i_done_hold) state_d = ARRAY_CSWITCH;
            LAST_SHIFT:  state_d = LAST_WAIT;
            // Last write to output memory in flight
            LAST_WAIT:   if (i_done_hold) state_d = DONE;
            DONE:        state_d = IDLE;
            default:     state_d = IDLE;
        endcase
    end

    // --------------------------------------------------
    // Output table
    // --------------------------------------------------

    // Columns
    // cmd  fs fr pg or ce cf dn
    // en   output buffer enable
    // req  cr fs sr
    always_comb begin
        case (state_q)
            IDLE:                {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0101001, 1'b0, 3'b000};
            START_FLAGS:         {o_cmd, o_outbuf_enable, o_stall_req} = {7'b1000000, 1'b1, 3'b000};
            ARRAY_PREP:          {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0000000, 1'b0, 3'b100};
            FIRST_SHIFT:         {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0000000, 1'b1, 3'b100};
            START_COMP:          {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0010110, 1'b0, 3'b100};
            WAIT_CSWITCH:        {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0010100, 1'b0, 3'b100};
            WAIT_CSWITCH_STALL:  {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0000100, 1'b0, 3'b100};
            WAIT_OBUF:           {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0010000, 1'b0, 3'b100};
            WAIT_OBUF_STALL:     {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0000000, 1'b0, 3'b100};
            SCND_SHIFT:          {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0010000, 1'b1, 3'b100};
            SCND_SHIFT_STALL:    {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0000000, 1'b1, 3'b100};
            ALL_BUSY_SHIFT:      {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0010000, 1'b1, 3'b100};
            // Array may stall on cdone while the buffer still works
            ALL_BUSY:            {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0010000, 1'b1, 3'b000};
            ARRAY_BUSY:          {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0010100, 1'b0, 3'b100};
            OBUF_BUSY_SHIFT:     {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0000000, 1'b1, 3'b100};
            FORCE_STALL:         {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0000000, 1'b0, 3'b010};
            OBUF_BUSY:           {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0010000, 1'b1, 3'b000};
            ARRAY_CSWITCH:       {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0010100, 1'b0, 3'b100};
            ARRAY_CSWITCH_STALL: {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0000100, 1'b0, 3'b100};
            LAST_SHIFT:          {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0000000, 1'b1, 3'b100};
            LAST_WAIT:           {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0000000, 1'b0, 3'b100};
            // Resets asserted again and the stall machine cleared
            DONE:                {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0101001, 1'b0, 3'b001};
            default:             {o_cmd, o_outbuf_enable, o_stall_req} = {7'b0101000, 1'b0, 3'b000};
        endcase
    end

    // Status is the state code, unused codes report as invalid
    always_comb begin
        case (state_q)
            IDLE: o_status = ctx_status_t'(`CTX_STATUS_IDLE);
            DONE: o_status = ctx_status_t'(`CTX_STATUS_DONE);
            START_FLAGS, ARRAY_PREP, FIRST_SHIFT, START_COMP, WAIT_CSWITCH,
            WAIT_CSWITCH_STALL, WAIT_OBUF, WAIT_OBUF_STALL, SCND_SHIFT,
            SCND_SHIFT_STALL, ALL_BUSY_SHIFT, ALL_BUSY, ARRAY_BUSY,
            OBUF_BUSY_SHIFT, FORCE_STALL, OBUF_BUSY, ARRAY_CSWITCH,
            ARRAY_CSWITCH_STALL, LAST_SHIFT, LAST_WAIT: begin
                o_status = ctx_status_t'(state_q);
            end
            default: o_status = ctx_status_t'(`CTX_STATUS_INVALID);
        endcase
    end

endmodule

/* source/pipeline_stall_ctrl.sv */
`timescale 1ns/1ps

module pipeline_stall_ctrl (
    input  logic                i_clk,
    input  logic                i_rstn,
    // Ready, force and reset requests from the sequencer
    input  ctx_pkg::stall_req_t i_req,
    // Current context has entered the array
    input  logic                i_cdone,
    // Master enable of the array pipeline
    output logic                o_pipeline_gate
);

    import ctx_pkg::*;

    stall_state_e state_q;
    stall_state_e state_d;

    // Pipeline starts stalled
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state_q <= ARRAY_STALL;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------------------------------------
    // Stall transitions
    // --------------------------------------------------

    always_comb begin
        state_d = state_q;
        // Job end returns the array to stall whatever the state
        if (i_req.stall_reset) begin
            state_d = ARRAY_STALL;
        end else begin
            case (state_q)
                // Stop on a forced stall or when the context ends unready
                ARRAY_ACTIVE: begin
                    if (i_req.force_stall || (i_cdone && !i_req.computation_ready)) begin
                        state_d = ARRAY_STALL;
                    end
                end
                // Resume once computation is ready
                ARRAY_STALL: if (i_req.computation_ready) state_d = ARRAY_ACTIVE;
                default:     state_d = ARRAY_STALL;
            endcase
        end
    end

    // Gate open only while active
    assign o_pipeline_gate = (state_q == ARRAY_ACTIVE);

endmodule

/* source/obuf_handshake.sv */
`timescale 1ns/1ps

module obuf_handshake (
    input  logic i_clk,
    input  logic i_rstn,
    // Done level from the output buffer
    input  logic i_outbuf_done,
    // Enable level from the sequencer
    input  logic i_enable,
    // Buffer reset command from the sequencer
    input  logic i_outbuf_reset,
    // Start pulse, first cycle of each enable run
    output logic o_outbuf_start,
    // Done seen since the last start or reset
    output logic o_done_hold
);

    logic enable_q;
    logic done_q;

    // --------------------------------------------------
    // Start edge
    // --------------------------------------------------

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            enable_q <= 1'b0;
        end else begin
            enable_q <= i_enable;
        end
    end

    // Rising edge of the enable level
    assign o_outbuf_start = i_enable && !enable_q;

    // --------------------------------------------------
    // Done hold
    // --------------------------------------------------

    // A fresh done wins over the clear in the same cycle
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            done_q <= 1'b0;
        end else if (i_outbuf_done) begin
            done_q <= 1'b1;
        end else if (o_outbuf_start || i_outbuf_reset) begin
            done_q <= 1'b0;
        end
    end

    // Live done passes straight through unless a new start or reset is out
    assign o_done_hold = (i_outbuf_done || done_q) && !(o_outbuf_start || i_outbuf_reset);

endmodule

/* source/ctx_ctrl_top.sv */
`timescale 1ns/1ps

module ctx_ctrl_top (
    input  logic                 i_clk,
    input  logic                 i_rstn,
    // Event levels, sampled on the rising edge
    input  ctx_pkg::ctx_event_t  i_evt,
    // Level commands to the neighbouring blocks
    output ctx_pkg::ctx_cmd_t    o_cmd,
    // One cycle start for the output buffer
    output logic                 o_outbuf_start,
    // Array pipeline enable
    output logic                 o_pipeline_gate,
    // Sequencer state code
    output ctx_pkg::ctx_status_t o_status
);

    import ctx_pkg::*;

    // --------------------------------------------------
    // Internal links
    // --------------------------------------------------

    // Sequencer to stall machine
    stall_req_t stall_req;
    // Sequencer to buffer handshake
    logic       outbuf_enable;
    // Buffer handshake back to sequencer
    logic       done_hold;

    // Main context state machine
    ctx_sequencer ctx_sequencer_i (
        .i_clk           (i_clk),
        .i_rstn          (i_rstn),
        .i_evt           (i_evt),
        .i_done_hold     (done_hold),
        .o_cmd           (o_cmd),
        .o_stall_req     (stall_req),
        .o_outbuf_enable (outbuf_enable),
        .o_status        (o_status)
    );

    // Array pipeline gate
    pipeline_stall_ctrl pipeline_stall_ctrl_i (
        .i_clk           (i_clk),
        .i_rstn          (i_rstn),
        .i_req           (stall_req),
        .i_cdone         (i_evt.cdone),
        .o_pipeline_gate (o_pipeline_gate)
    );

    // Buffer start pulse and done hold
    // Buffer reset comes from the sequencer command vector
    obuf_handshake obuf_handshake_i (
        .i_clk          (i_clk),
        .i_rstn         (i_rstn),
        .i_outbuf_done  (i_evt.outbuf_done),
        .i_enable       (outbuf_enable),
        .i_outbuf_reset (o_cmd.outbuf_reset),
        .o_outbuf_start (o_outbuf_start),
        .o_done_hold    (done_hold)
    );

endmodule

/* sim/ctx_tb_chk.sv */
`timescale 1ns/1ps
`include "ctx_cfg.svh"

module ctx_tb_chk (
    input logic                 i_clk,
    input logic                 i_rstn,
    input ctx_pkg::ctx_cmd_t    i_cmd,
    input logic                 i_outbuf_start,
    input logic                 i_pipeline_gate,
    input ctx_pkg::ctx_status_t i_status
);

    import ctx_pkg::*;

    // --------------------------------------------------
    // Output buffer start
    // --------------------------------------------------

    // Start only in the first cycle of a newly entered state
    start_on_entry: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        i_outbuf_start |-> (i_status != $past(i_status))
    ) else $error("output buffer start without a state change");

    // --------------------------------------------------
    // Job handshake and status
    // --------------------------------------------------

    // Done only in idle or at the end of a job
    done_in_idle_or_done: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        i_cmd.done |-> (i_status == ctx_status_t'(`CTX_STATUS_IDLE) ||
                        i_status == ctx_status_t'(`CTX_STATUS_DONE))
    ) else $error("done command raised outside idle and done");

    // Stall reset in DONE closes the pipeline gate
    gate_closed_after_done: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        (i_status == ctx_status_t'(`CTX_STATUS_DONE)) |=> !i_pipeline_gate
    ) else $error("pipeline gate still open after the job ended");

    // Done code lasts one cycle, then back to idle
    done_one_cycle: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        (i_status == ctx_status_t'(`CTX_STATUS_DONE)) |=>
        (i_status == ctx_status_t'(`CTX_STATUS_IDLE))
    ) else $error("done status not followed by idle");

endmodule

bind ctx_ctrl_top ctx_tb_chk ctx_tb_chk_i (
    .i_clk           (i_clk),
    .i_rstn          (i_rstn),
    .i_cmd           (o_cmd),
    .i_outbuf_start  (o_outbuf_start),
    .i_pipeline_gate (o_pipeline_gate),
    .i_status        (o_status)
);

/* sim/ctx_tb.sv */
`timescale 1ns/1ps
`include "ctx_cfg.svh"

module ctx_tb;

    import ctx_pkg::*;

    // Longest wait for a status change, in cycles
    localparam int unsigned max_wait = 50;

    // Single event levels, bit order as in ctx_event_t
    localparam ctx_event_t start_evt     = 8'b1000_0000;
    localparam ctx_event_t obuf_done_evt = 8'b0100_0000;
    localparam ctx_event_t cdone_evt     = 8'b0010_0000;
    localparam ctx_event_t cswitch_evt   = 8'b0001_0000;
    localparam ctx_event_t shift_evt     = 8'b0000_1000;
    localparam ctx_event_t final_evt     = 8'b0000_0100;
    localparam ctx_event_t pipe_evt      = 8'b0000_0001;
    // Context switch done on the last context, feeders finished
    localparam ctx_event_t last_evt      = 8'b0001_0110;

    logic        i_clk;
    logic        i_rstn;
    ctx_event_t  i_evt;
    ctx_cmd_t    o_cmd;
    logic        o_outbuf_start;
    logic        o_pipeline_gate;
    ctx_status_t o_status;

    int unsigned error_count;
    int unsigned tests_passed;
    int unsigned tests_failed;

    ctx_ctrl_top ctx_ctrl_top_i (
        .i_clk           (i_clk),
        .i_rstn          (i_rstn),
        .i_evt           (i_evt),
        .o_cmd           (o_cmd),
        .o_outbuf_start  (o_outbuf_start),
        .o_pipeline_gate (o_pipeline_gate),
        .o_status        (o_status)
    );

    // 8 ns clock
    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------

    task automatic check_status(input ctx_status_t act, input ctx_status_t exp, input string msg);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s, status %0d, expected %0d", $time, msg, act, exp);
            error_count++;
        end
    endtask

    task automatic check_cmd(input ctx_cmd_t act, input ctx_cmd_t exp, input string msg);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s, cmd %b, expected %b", $time, msg, act, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string msg);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, msg, act, exp);
            error_count++;
        end
    endtask

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------

    // One cycle event, sampled on a single rising edge
    task automatic pulse(input ctx_event_t e);
        @(posedge i_clk);
        i_evt <= e;
        @(posedge i_clk);
        i_evt <= '0;
    endtask

    // Wait for the status to leave cur, then compare with the next state
    task automatic wait_change(input ctx_state_e cur, input ctx_state_e exp,
                               input int unsigned limit);
        int unsigned cycles;
        cycles = 0;
        do begin
            @(negedge i_clk);
            cycles++;
        end while (o_status == ctx_status_t'(cur) && cycles < limit);
        if (o_status == ctx_status_t'(cur)) begin
            $display("Timeout at %0t: status stuck at %0d while waiting for %0d",
                     $time, o_status, exp);
            error_count++;
        end else begin
            check_status(o_status, ctx_status_t'(exp), "next state");
        end
    endtask

    // Random idle gap, then one event and one expected transition
    task automatic send(input ctx_event_t e, input ctx_state_e exp);
        ctx_state_e  cur;
        int unsigned gap;
        gap = $urandom % 4;
        repeat (gap) @(negedge i_clk);
        cur = ctx_state_e'(o_status);
        pulse(e);
        wait_change(cur, exp, max_wait);
    endtask

    // Job start through preload and first shift up to the first loop entry
    task automatic run_to_all_busy_shift();
        ctx_cmd_t exp;
        exp = '0;
        exp.feeders_start = 1'b1;
        pulse(start_evt);
        wait_change(IDLE, START_FLAGS, 1);
        check_cmd(o_cmd, exp, "feeders start at job start");
        check_bit(o_outbuf_start, 1'b1, "preload start pulse");
        wait_change(START_FLAGS, ARRAY_PREP, 1);
        send(obuf_done_evt, FIRST_SHIFT);
        send(shift_evt, START_COMP);
        send(pipe_evt, WAIT_CSWITCH);
        send(cswitch_evt, WAIT_OBUF);
        send(obuf_done_evt, SCND_SHIFT);
        wait_change(SCND_SHIFT, ALL_BUSY_SHIFT, 1);
    endtask

    // Last shift, last write and the return to idle
    task automatic finish_job();
        wait_change(LAST_SHIFT, LAST_WAIT, 1);
        send(obuf_done_evt, DONE);
        check_bit(o_cmd.done, 1'b1, "done at job end");
        wait_change(DONE, IDLE, 1);
        check_bit(o_pipeline_gate, 1'b0, "gate closed in idle");
    endtask

    task automatic report_test(input string name, input int unsigned errs_before);
        if (error_count == errs_before) begin
            $display("Test %s: ok", name);
            tests_passed++;
        end else begin
            $display("Test %s: FAILED with %0d errors", name, error_count - errs_before);
            tests_failed++;
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic test_reset_values();
        int unsigned errs;
        ctx_cmd_t    exp;
        errs = error_count;
        exp = '0;
        exp.feeders_reset = 1'b1;
        exp.outbuf_reset = 1'b1;
        exp.done = 1'b1;
        check_status(o_status, ctx_status_t'(`CTX_STATUS_IDLE), "status after reset");
        check_cmd(o_cmd, exp, "commands after reset");
        check_bit(o_pipeline_gate, 1'b0, "gate after reset");
        check_bit(o_outbuf_start, 1'b0, "start pulse after reset");
        report_test("reset values", errs);
    endtask

    task automatic test_shortest_job();
        int unsigned errs;
        errs = error_count;
        run_to_all_busy_shift();
        send(shift_evt, ALL_BUSY);
        send(obuf_done_evt | cdone_evt, ARRAY_CSWITCH);
        send(last_evt, LAST_SHIFT);
        finish_job();
        report_test("shortest job", errs);
    endtask

    // Buffer done during the shift is kept until the buffer is needed
    task automatic test_held_done();
        int unsigned errs;
        errs = error_count;
        run_to_all_busy_shift();
        pulse(obuf_done_evt);
        @(negedge i_clk);
        check_status(o_status, ctx_status_t'(ALL_BUSY_SHIFT), "done alone keeps the shift");
        send(shift_evt, ALL_BUSY);
        wait_change(ALL_BUSY, ARRAY_BUSY, 1);
        send(cdone_evt, ARRAY_CSWITCH);
        send(last_evt, LAST_SHIFT);
        finish_job();
        report_test("held done", errs);
    endtask

    task automatic test_forced_stall();
        int unsigned errs;
        errs = error_count;
        run_to_all_busy_shift();
        check_bit(o_pipeline_gate, 1'b1, "gate open before forced stall");
        send(cdone_evt | shift_evt, FORCE_STALL);
        wait_change(FORCE_STALL, OBUF_BUSY, 1);
        check_bit(o_pipeline_gate, 1'b0, "gate closed after forced stall");
        send(obuf_done_evt, ARRAY_CSWITCH);
        send(last_evt, LAST_SHIFT);
        finish_job();
        report_test("forced stall", errs);
    endtask

    // Loop back without final write, then exit from the stalled switch
    task automatic test_loop_exits();
        int unsigned errs;
        errs = error_count;
        run_to_all_busy_shift();
        send(shift_evt, ALL_BUSY);
        send(obuf_done_evt | cdone_evt, ARRAY_CSWITCH);
        send(cswitch_evt, ALL_BUSY_SHIFT);
        send(shift_evt, ALL_BUSY);
        send(obuf_done_evt | cdone_evt, ARRAY_CSWITCH);
        send(cdone_evt, ARRAY_CSWITCH_STALL);
        // Feeders done stays low here
        send(cswitch_evt | final_evt, LAST_SHIFT);
        finish_job();
        report_test("loop exits", errs);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        void'($urandom(62466));
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        i_rstn = 1'b0;
        i_evt = '0;
        repeat (3) @(posedge i_clk);
        i_rstn <= 1'b1;
        @(negedge i_clk);
        test_reset_values();
        test_shortest_job();
        test_held_done();
        test_forced_stall();
        test_loop_exits();
        $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+common
common/ctx_pkg.sv
sequencer/ctx_sequencer.sv
source/pipeline_stall_ctrl.sv
source/obuf_handshake.sv
source/ctx_ctrl_top.sv
sim/ctx_tb_chk.sv
sim/ctx_tb.sv
